//--- verilog.f
src/filter_stream_pkg.sv
src/filter_cfg_pkg.sv
src/filter_regs.sv
src/filter_bincu.sv
src/filter_out_fifo.sv
src/filter_top.sv
tests/filter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the binarization filter testbench with Verilator, runs it
# and decides pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --top-module filter_tb \
  -Mdir "$build_dir" -o filter_sim -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/filter_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$log_file"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- tests/filter_tb.sv
/*
 * Directed testbench for the binarization filter
 * drives register writes and the input stream on the falling edge,
 * checks binarized beats, the match counter and the activity event
 */

`timescale 1ns/10ps

module filter_tb;

  localparam int TRANS_SIZE = 16;
  localparam int FIFO_DEPTH = 4;
  localparam int MAX_CYCLES = 4000;

  logic                     clk_i;
  logic                     resetn_i;
  logic                     reg_wr_i;
  logic [3:0]               reg_addr_i;
  logic [31:0]              reg_wdata_i;
  filter_stream_pkg::beat_t in_beat_i;
  logic                     in_valid_i;
  logic                     in_ready_o;
  filter_stream_pkg::beat_t out_beat_o;
  logic                     out_valid_o;
  logic                     out_ready_i;
  logic [TRANS_SIZE-1:0]    counter_val_o;
  logic                     act_event_o;

  // model of the configuration as last written by the host
  logic        m_signed;
  logic        m_out_en;
  logic        m_cnt_en;
  logic [1:0]  m_size;
  logic [31:0] m_thr;
  logic [15:0] m_target;
  logic [15:0] m_count;
  logic [31:0] lcg_state;

  // expected beats in arrival order, pushed by the stimulus and popped by the monitor
  filter_stream_pkg::beat_t exp_q [$];
  // activity events the model predicts and the ones the monitor saw
  int ev_due;
  int ev_seen;
  int task_errors;
  int mon_errors;
  int cycles;

  filter_top #(
    .TRANS_SIZE (TRANS_SIZE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // result bit of the binarization rule for one input word
  function automatic logic expect_bit(logic [31:0] word);
    logic [31:0] ext;
    if (m_size == 2'd0) begin
      ext = {{24{m_signed & word[7]}}, word[7:0]};
    end else if (m_size == 2'd1) begin
      ext = {{16{m_signed & word[15]}}, word[15:0]};
    end else begin
      ext = word;
    end
    // flipping both sign bits turns a signed compare into an unsigned one
    if (m_signed) begin
      return (ext ^ 32'h8000_0000) > (m_thr ^ 32'h8000_0000);
    end
    return ext > m_thr;
  endfunction

  //////////////////////////////////////////////////
  // host and stream drivers
  //////////////////////////////////////////////////

  // called on a falling edge so that the write lands at the next rising edge
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    reg_wr_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_wr_i = 1'b0;
  endtask

  task automatic set_ctrl(input logic sgn, input logic oen, input logic cen,
                          input logic [1:0] size);
    m_signed = sgn;
    m_out_en = oen;
    m_cnt_en = cen;
    m_size   = size;
    write_reg(filter_cfg_pkg::REG_CTRL, {27'd0, size, cen, oen, sgn});
  endtask

  task automatic set_threshold(input logic [31:0] thr);
    m_thr = thr;
    write_reg(filter_cfg_pkg::REG_THRESHOLD, thr);
  endtask

  task automatic set_target(input logic [15:0] target);
    m_target = target;
    write_reg(filter_cfg_pkg::REG_TARGET, {16'd0, target});
  endtask

  // the counter clears one edge after the command write
  task automatic start_run();
    write_reg(filter_cfg_pkg::REG_CMD, 32'd1);
    @(negedge clk_i);
    m_count = 16'd0;
  endtask

  // holds the beat until the DUT takes it, then updates the model
  task automatic send_beat(input logic [31:0] word, input logic sof, input logic eof);
    filter_stream_pkg::beat_t beat;
    logic                     accepted;
    logic                     bit_exp;
    beat.data.word = word;
    beat.size      = filter_stream_pkg::size_e'(m_size);
    beat.sof       = sof;
    beat.eof       = eof;
    in_beat_i      = beat;
    in_valid_i     = 1'b1;
    accepted       = 1'b0;
    while (!accepted) begin
      @(posedge clk_i);
      accepted = in_ready_o;
      @(negedge clk_i);
    end
    in_valid_i = 1'b0;
    bit_exp    = expect_bit(word);
    if (m_out_en) begin
      beat.data.word = {31'd0, bit_exp};
      exp_q.push_back(beat);
    end
    if (m_cnt_en && bit_exp) begin
      m_count = m_count + 16'd1;
      if (m_count == m_target) begin
        ev_due = ev_due + 1;
      end
    end
  endtask

  task automatic check_count();
    if (counter_val_o !== m_count) begin
      $display("FAILED at %0t: counter %0d, expected %0d", $time, counter_val_o, m_count);
      task_errors = task_errors + 1;
    end
  endtask

  task automatic drain_output();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    if (out_valid_o !== 1'b0) begin
      $display("FAILED at %0t: output still valid after every expected beat arrived",
               $time);
      task_errors = task_errors + 1;
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic unsigned_8bit_beats();
    set_ctrl(1'b0, 1'b1, 1'b0, 2'd0);
    set_threshold(32'h0000_0090);
    for (int i = 0; i < 40; i++) begin
      send_beat(lcg_next(), i == 0, i == 39);
    end
    drain_output();
  endtask

  // top-bit samples are negative when signed and large when unsigned
  task automatic signed_compare();
    logic [31:0] samples [8];
    samples = '{32'h1234_8000, 32'h0000_ffff, 32'h5a5a_0010, 32'hffff_ff00,
                32'h0000_7fff, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ff9c};
    set_ctrl(1'b1, 1'b1, 1'b0, 2'd1);
    set_threshold(32'hffff_ff9c);
    for (int i = 0; i < 8; i++) begin
      send_beat(samples[i], i == 0, 1'b0);
      send_beat(lcg_next(), 1'b0, i == 7);
    end
    set_ctrl(1'b0, 1'b1, 1'b0, 2'd1);
    set_threshold(32'h0000_7fff);
    for (int i = 0; i < 8; i++) begin
      send_beat(samples[i], i == 0, i == 7);
    end
    set_ctrl(1'b1, 1'b1, 1'b0, 2'd2);
    set_threshold(32'hffff_ff9c);
    for (int i = 0; i < 8; i++) begin
      send_beat(samples[i], i == 0, i == 7);
    end
    drain_output();
  endtask

  // every even beat is forced above the threshold so the target is reached
  task automatic counter_and_event();
    int          seen_before;
    logic [31:0] word;
    set_threshold(32'h0000_007f);
    set_target(16'd5);
    set_ctrl(1'b0, 1'b1, 1'b1, 2'd0);
    start_run();
    seen_before = ev_seen;
    for (int run = 0; run < 2; run++) begin
      for (int i = 0; i < 12; i++) begin
        word = lcg_next();
        if (i % 2 == 0) begin
          word[7] = 1'b1;
        end
        send_beat(word, i == 0, i == 11);
        check_count();
      end
      if (run == 0) begin
        start_run();
        check_count();
      end
    end
    repeat (2) @(negedge clk_i);
    if (ev_seen - seen_before != 2) begin
      $display("FAILED at %0t: activity event fired %0d times over two runs, expected 2",
               $time, ev_seen - seen_before);
      task_errors = task_errors + 1;
    end
    drain_output();
  endtask

  // a threshold inside the byte range gives a mix of 0 and 1 beats
  task automatic fifo_backpressure();
    set_ctrl(1'b0, 1'b1, 1'b0, 2'd0);
    set_threshold(32'h0000_0080);
    out_ready_i = 1'b0;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      send_beat(lcg_next(), i == 0, 1'b0);
    end
    if (in_ready_o !== 1'b0) begin
      $display("FAILED at %0t: in_ready_o still high with a full FIFO", $time);
      task_errors = task_errors + 1;
    end
    // the sender stalls until the consumer is released
    fork
      for (int j = 0; j < 4; j++) begin
        send_beat(lcg_next(), 1'b0, j == 3);
      end
      begin
        repeat (6) @(negedge clk_i);
        out_ready_i = 1'b1;
      end
    join
    drain_output();
  endtask

  task automatic output_disabled();
    set_target(16'hffff);
    set_ctrl(1'b0, 1'b0, 1'b1, 2'd0);
    start_run();
    for (int i = 0; i < 16; i++) begin
      send_beat(lcg_next(), i == 0, i == 15);
      if (in_ready_o !== 1'b1 || out_valid_o !== 1'b0) begin
        $display("FAILED at %0t: in_ready_o %b, out_valid_o %b, expected 1 and 0",
                 $time, in_ready_o, out_valid_o);
        task_errors = task_errors + 1;
      end
      check_count();
    end
  endtask

  //////////////////////////////////////////////////
  // output monitor and timeout
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    filter_stream_pkg::beat_t exp_beat;
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end else begin
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("unexpected output beat %h at %0t", out_beat_o, $time);
          mon_errors = mon_errors + 1;
        end else begin
          exp_beat = exp_q.pop_front();
          if (out_beat_o !== exp_beat) begin
            $display("FAILED at %0t: output beat %h, expected %h", $time, out_beat_o,
                     exp_beat);
            mon_errors = mon_errors + 1;
          end
        end
      end
      // an event is due in the cycle right after the count hits the target
      if (act_event_o) begin
        if (ev_seen >= ev_due) begin
          $display("activity event at %0t without a new target match", $time);
          mon_errors = mon_errors + 1;
        end
        ev_seen = ev_seen + 1;
      end else if (ev_due > ev_seen) begin
        $display("activity event missing at %0t after the count reached the target", $time);
        mon_errors = mon_errors + 1;
        ev_seen = ev_due;
      end
    end
  end

  initial begin
    resetn_i    = 1'b0;
    reg_wr_i    = 1'b0;
    reg_addr_i  = 4'd0;
    reg_wdata_i = 32'd0;
    in_beat_i   = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    m_signed    = 1'b0;
    m_out_en    = 1'b0;
    m_cnt_en    = 1'b0;
    m_size      = 2'd0;
    m_thr       = 32'd0;
    m_target    = 16'd0;
    m_count     = 16'd0;
    lcg_state   = 32'h50be;
    ev_due      = 0;
    ev_seen     = 0;
    task_errors = 0;
    mon_errors  = 0;
    cycles      = 0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    resetn_i = 1'b1;
    @(negedge clk_i);
    unsigned_8bit_beats();
    signed_compare();
    fifo_backpressure();
    counter_and_event();
    output_disabled();
    $display("summary: %0d errors", task_errors + mon_errors);
    if (task_errors + mon_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src/filter_top.sv
/*
 * Binarization filter top level
 * register block, binarizer and output FIFO on one stream path
 */

`timescale 1ns/10ps

module filter_top #(
  parameter int unsigned TRANS_SIZE = 16,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     resetn_i,

  // host register writes
  input  logic                     reg_wr_i,
  input  logic [3:0]               reg_addr_i,
  input  logic [31:0]              reg_wdata_i,

  // input sample stream
  input  filter_stream_pkg::beat_t in_beat_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,

  // binarized output stream
  output filter_stream_pkg::beat_t out_beat_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,

  // counter status
  output logic [TRANS_SIZE-1:0]    counter_val_o,
  output logic                     act_event_o
);

  filter_cfg_pkg::cfg_t     cfg;
  logic                     start;
  filter_stream_pkg::beat_t bin_beat;
  logic                     bin_valid;
  logic                     bin_ready;

  filter_regs u_regs (
    .clk_i       (clk_i),
    .resetn_i    (resetn_i),
    .reg_wr_i    (reg_wr_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .cfg_o       (cfg),
    .start_o     (start)
  );

  filter_bincu #(
    .TRANS_SIZE (TRANS_SIZE)
  ) u_bincu (
    .clk_i         (clk_i),
    .resetn_i      (resetn_i),
    .cfg_i         (cfg),
    .start_i       (start),
    .in_beat_i     (in_beat_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .bin_beat_o    (bin_beat),
    .bin_valid_o   (bin_valid),
    .bin_ready_i   (bin_ready),
    .counter_val_o (counter_val_o),
    .act_event_o   (act_event_o)
  );

  // the FIFO sits directly behind the combinational binarizer
  filter_out_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_out_fifo (
    .clk_i      (clk_i),
    .resetn_i   (resetn_i),
    .wr_beat_i  (bin_beat),
    .wr_valid_i (bin_valid),
    .wr_ready_o (bin_ready),
    .rd_beat_o  (out_beat_o),
    .rd_valid_o (out_valid_o),
    .rd_ready_i (out_ready_i)
  );

endmodule

//--- src/filter_out_fifo.sv
/*
 * Output FIFO for binarized beats
 * circular buffer with read and write pointers and an occupancy count,
 * back-pressure toward the binarizer when full
 */

`timescale 1ns/10ps

module filter_out_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     resetn_i,

  input  filter_stream_pkg::beat_t wr_beat_i,
  input  logic                     wr_valid_i,
  output logic                     wr_ready_o,

  output filter_stream_pkg::beat_t rd_beat_o,
  output logic                     rd_valid_o,
  input  logic                     rd_ready_i
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  filter_stream_pkg::beat_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign wr_ready_o = (count_q != CNT_W'(FIFO_DEPTH));
  assign rd_valid_o = (count_q != '0);
  assign push       = wr_valid_i & wr_ready_o;
  assign pop        = rd_valid_o & rd_ready_i;

  // the oldest entry is always on the read side
  assign rd_beat_o = mem[rd_ptr_q];

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= wr_beat_i;
    end
  end

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the count unchanged
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assert_count_bound : assert property (
    @(posedge clk_i) disable iff (!resetn_i)
    count_q <= CNT_W'(FIFO_DEPTH)
  ) else $error("FIFO occupancy above its depth");

endmodule

//--- src/filter_bincu.sv
/*
 * Binarization and counting unit
 * extends each sample to a full word, compares it with the threshold
 * and replaces the data with the result bit, counts matches and
 * raises a one-cycle event when the count hits the target
 */

`timescale 1ns/10ps

module filter_bincu #(
  parameter int unsigned TRANS_SIZE = 16
) (
  input  logic                    clk_i,
  input  logic                    resetn_i,

  input  filter_cfg_pkg::cfg_t    cfg_i,
  input  logic                    start_i,

  input  filter_stream_pkg::beat_t in_beat_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,

  output filter_stream_pkg::beat_t bin_beat_o,
  output logic                    bin_valid_o,
  input  logic                    bin_ready_i,

  output logic [TRANS_SIZE-1:0]   counter_val_o,
  output logic                    act_event_o
);

  filter_stream_pkg::sample_u                sample;
  logic [filter_stream_pkg::DATA_WIDTH-1:0]  ext_word;
  logic                                      th_event;
  logic                                      accept;
  logic                                      target_match;
  logic                                      match_hist_q;
  logic [TRANS_SIZE-1:0]                     counter_q;

  //////////////////////////////////////////////////
  // sample decode and compare
  //////////////////////////////////////////////////

  assign sample = in_beat_i.data;

  // the configured size picks the union view, the sign bit of the
  // narrow sample is only replicated in signed mode
  always_comb begin
    case (cfg_i.datasize)
      filter_stream_pkg::SIZE_8: begin
        ext_word = {{24{cfg_i.use_signed & sample.bytes[0][7]}}, sample.bytes[0]};
      end
      filter_stream_pkg::SIZE_16: begin
        ext_word = {{16{cfg_i.use_signed & sample.half[0][15]}}, sample.half[0]};
      end
      default: begin
        ext_word = sample.word;
      end
    endcase
  end

  assign th_event = cfg_i.use_signed ? ($signed(ext_word) > $signed(cfg_i.threshold)) :
                                       (ext_word > cfg_i.threshold);

  // the beat keeps its size and framing, only the data becomes 0 or 1
  always_comb begin
    bin_beat_o           = in_beat_i;
    bin_beat_o.data.word = {{(filter_stream_pkg::DATA_WIDTH-1){1'b0}}, th_event};
  end

  // with the output off every beat is swallowed here
  assign bin_valid_o = in_valid_i & cfg_i.out_enable;
  assign in_ready_o  = cfg_i.out_enable ? bin_ready_i : 1'b1;
  assign accept      = in_valid_i & in_ready_o;

  //////////////////////////////////////////////////
  // match counter and activity event
  //////////////////////////////////////////////////

  assign target_match = (counter_q == TRANS_SIZE'(cfg_i.count_target));

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      counter_q    <= '0;
      match_hist_q <= 1'b0;
    end else if (start_i) begin
      counter_q    <= '0;
      match_hist_q <= 1'b0;
    end else begin
      // remembers that the target was already seen last cycle
      match_hist_q <= target_match;
      if (cfg_i.en_counter && accept && th_event) begin
        counter_q <= counter_q + 1'b1;
      end
    end
  end

  // fires in the first cycle the registered count equals the target
  assign act_event_o   = cfg_i.en_counter & target_match & ~match_hist_q;
  assign counter_val_o = counter_q;

  assert_event_single : assert property (
    @(posedge clk_i) disable iff (!resetn_i)
    act_event_o && !start_i |=> !act_event_o
  ) else $error("activity event lasted more than one cycle");

  assert_no_valid_when_off : assert property (
    @(posedge clk_i) disable iff (!resetn_i)
    !cfg_i.out_enable |-> !bin_valid_o
  ) else $error("binarized beat offered while output is disabled");

endmodule

//--- src/filter_regs.sv
/*
 * Filter register block
 * takes single-cycle write strobes from the host, holds the active
 * configuration and turns command writes into a one-cycle start pulse
 */

`timescale 1ns/10ps

module filter_regs (
  input  logic                  clk_i,
  input  logic                  resetn_i,

  input  logic                  reg_wr_i,
  input  logic [3:0]            reg_addr_i,
  input  logic [31:0]           reg_wdata_i,

  output filter_cfg_pkg::cfg_t  cfg_o,
  output logic                  start_o
);

  filter_cfg_pkg::cfg_t cfg_q;
  logic                 start_q;
  logic                 cmd_start;

  // a command write only starts a run when the start bit is set
  assign cmd_start = reg_wr_i && (reg_addr_i == filter_cfg_pkg::REG_CMD) &&
                     reg_wdata_i[filter_cfg_pkg::CMD_START_BIT];

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////

  // every field comes out of reset as zero, which means unsigned,
  // output disabled, counter disabled, 8-bit samples, threshold 0
  // and target 0
  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      cfg_q <= '0;
    end else if (reg_wr_i) begin
      case (reg_addr_i)
        filter_cfg_pkg::REG_CTRL: begin
          cfg_q.use_signed <= reg_wdata_i[filter_cfg_pkg::CTRL_SIGNED_BIT];
          cfg_q.out_enable <= reg_wdata_i[filter_cfg_pkg::CTRL_OUTEN_BIT];
          cfg_q.en_counter <= reg_wdata_i[filter_cfg_pkg::CTRL_CNTEN_BIT];
          // code 3 is kept as is and read as a 32-bit size downstream
          cfg_q.datasize   <= filter_stream_pkg::size_e'(
            reg_wdata_i[filter_cfg_pkg::CTRL_SIZE_MSB:filter_cfg_pkg::CTRL_SIZE_LSB]);
        end
        filter_cfg_pkg::REG_THRESHOLD: begin
          cfg_q.threshold <= reg_wdata_i;
        end
        filter_cfg_pkg::REG_TARGET: begin
          cfg_q.count_target <= reg_wdata_i[15:0];
        end
        default: begin
          // the command register holds no state and other
          // addresses are not mapped, so nothing is stored
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // start command
  //////////////////////////////////////////////////

  // the pulse is high for the cycle after the command write, so the
  // binarizer clears its counter at the following edge
  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= cmd_start;
    end
  end

  assign cfg_o   = cfg_q;
  assign start_o = start_q;

  // the host is expected to space command writes, so a start pulse
  // is never longer than one cycle
  assert_start_single : assert property (
    @(posedge clk_i) disable iff (!resetn_i)
    start_o |=> !start_o
  ) else $error("start pulse lasted more than one cycle");

endmodule

//--- src/filter_cfg_pkg.sv
/*
 * Configuration definitions for the binarization filter
 * the active configuration struct and the register map
 */

package filter_cfg_pkg;

  // active configuration as seen by the binarizer
  typedef struct packed {
    logic                                         use_signed;
    logic                                         out_enable;
    logic                                         en_counter;
    filter_stream_pkg::size_e                     datasize;
    logic [filter_stream_pkg::DATA_WIDTH-1:0]     threshold;
    // top width of the counter, the unit only compares TRANS_SIZE bits
    logic [15:0]                                  count_target;
  } cfg_t;

  //////////////////////////////////////////////////
  // register addresses
  //////////////////////////////////////////////////

  localparam logic [3:0] REG_CTRL      = 4'd0;
  localparam logic [3:0] REG_THRESHOLD = 4'd1;
  localparam logic [3:0] REG_TARGET    = 4'd2;
  localparam logic [3:0] REG_CMD       = 4'd3;

  // bit fields of the control register
  localparam int unsigned CTRL_SIGNED_BIT  = 0;
  localparam int unsigned CTRL_OUTEN_BIT   = 1;
  localparam int unsigned CTRL_CNTEN_BIT   = 2;
  localparam int unsigned CTRL_SIZE_LSB    = 3;
  localparam int unsigned CTRL_SIZE_MSB    = 4;

  // command register, bit 0 starts a new counting run
  localparam int unsigned CMD_START_BIT    = 0;

endpackage

//--- src/filter_stream_pkg.sv
/*
 * Stream definitions for the binarization filter
 * sample word width, sample size encoding, the decoded sample views
 * and the beat that travels on the valid/ready streams
 */

package filter_stream_pkg;

  // width of one sample word on the stream
  localparam int unsigned DATA_WIDTH = 32;

  // sample size carried with every beat and in the config
  // code 3 is not named and is decoded as a 32-bit sample as well
  typedef enum logic [1:0] {
    SIZE_8  = 2'd0,
    SIZE_16 = 2'd1,
    SIZE_32 = 2'd2
  } size_e;

  // one 32-bit word seen as a full word, two halfwords or four bytes
  typedef union packed {
    logic [DATA_WIDTH-1:0] word;
    logic [1:0][15:0]      half;
    logic [3:0][7:0]       bytes;
  } sample_u;

  // one stream beat, 36 bits
  typedef struct packed {
    sample_u data;
    size_e   size;
    logic    sof;
    logic    eof;
  } beat_t;

endpackage
